// File: all.f
hw/clock_pkg.sv
hw/sec_tick_gen.sv
hw/mode_ctrl.sv
hw/hms_counter.sv
hw/timer_counter.sv
hw/alarm_unit.sv
hw/digital_clock_top.sv
tests/tb_digital_clock.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_digital_clock
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_digital_clock.sv
//==============================
// Directed tests for the alarm
// clock, timer and watchdog
//==============================
`timescale 1ns/1ns

module tb_digital_clock import clock_pkg::*; ();

    localparam int CLKS_PER_SEC = 10;
    localparam int BTN_MODE = 0;
    localparam int BTN_POS  = 1;
    localparam int BTN_INC  = 2;
    localparam int BTN_CTL  = 3;
    // Rough length of each test in ticks, in run order
    localparam int TEST_TICKS = 15 + 2 + 80 + 60 + 10;
    localparam int WATCHDOG_CYCLES = TEST_TICKS * CLKS_PER_SEC + 400;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               i_mode_btn;
    logic               i_pos_btn;
    logic               i_inc_btn;
    logic               i_ctl_btn;
    logic [FIELD_W-1:0] o_hour;
    logic [FIELD_W-1:0] o_min;
    logic [FIELD_W-1:0] o_sec;
    mode_t              o_mode;
    pos_t               o_position;
    logic               o_running;
    logic               o_alarm_en;
    logic               o_alarm;

    logic [31:0] rng;
    int          exp_pos;
    int          exp_t [3];

    digital_clock_top #(
        .CLKS_PER_SEC (CLKS_PER_SEC)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_mode_btn (i_mode_btn),
        .i_pos_btn  (i_pos_btn),
        .i_inc_btn  (i_inc_btn),
        .i_ctl_btn  (i_ctl_btn),
        .o_hour     (o_hour),
        .o_min      (o_min),
        .o_sec      (o_sec),
        .o_mode     (o_mode),
        .o_position (o_position),
        .o_running  (o_running),
        .o_alarm_en (o_alarm_en),
        .o_alarm    (o_alarm)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Index 0 is seconds, 2 is hours
    function automatic int field_limit(input int p);
        return (p == 2) ? 23 : 59;
    endfunction

    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("CHECK FAILED: %s expected 0x%0h got 0x%0h", name, exp, got);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_display(input int h, input int m, input int s);
        check_eq("o_hour", int'(o_hour), h);
        check_eq("o_min", int'(o_min), m);
        check_eq("o_sec", int'(o_sec), s);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        exp_pos = 0;
        exp_t = '{0, 0, 0};
    endtask

    // One-cycle strobe, set and cleared on falling edges
    task automatic press(input int which);
        @(negedge clk);
        case (which)
            BTN_MODE: i_mode_btn = 1'b1;
            BTN_POS:  i_pos_btn = 1'b1;
            BTN_INC:  i_inc_btn = 1'b1;
            default:  i_ctl_btn = 1'b1;
        endcase
        @(negedge clk);
        i_mode_btn = 1'b0;
        i_pos_btn  = 1'b0;
        i_inc_btn  = 1'b0;
        i_ctl_btn  = 1'b0;
    endtask

    task automatic press_n(input int which, input int n);
        repeat (n) press(which);
    endtask

    task automatic wait_period();
        repeat (CLKS_PER_SEC) @(negedge clk);
    endtask

    task automatic wait_display(input int h, input int m, input int s, input int max_cycles);
        int n;
        n = 0;
        while (!(int'(o_hour) == h && int'(o_min) == m && int'(o_sec) == s)
               && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        check_true(int'(o_hour) == h && int'(o_min) == m && int'(o_sec) == s,
                   $sformatf("Timed out waiting for the display to read %0d:%0d:%0d", h, m, s));
    endtask

    task automatic select_pos(input int p);
        while (exp_pos != p) begin
            press(BTN_POS);
            exp_pos = (exp_pos + 1) % 3;
            check_eq("o_position", int'(o_position), exp_pos);
        end
    endtask

    // Model follows the no-carry wrap of a hand-stepped field
    task automatic step_field(input int p, input int k);
        select_pos(p);
        press_n(BTN_INC, k);
        exp_t[p] = (exp_t[p] + k) % (field_limit(p) + 1);
        check_display(exp_t[2], exp_t[1], exp_t[0]);
    endtask

    task automatic test_reset_and_count();
        apply_reset();
        check_display(0, 0, 0);
        check_eq("o_mode", int'(o_mode), int'(MODE_CLOCK));
        check_eq("o_position", int'(o_position), int'(POS_SEC));
        check_eq("o_running", int'(o_running), 0);
        check_eq("o_alarm_en", int'(o_alarm_en), 0);
        check_eq("o_alarm", int'(o_alarm), 0);
        for (int i = 1; i <= 12; i++) begin
            wait_period();
            check_display(0, 0, i % 60);
        end
    endtask

    task automatic test_mode_position();
        apply_reset();
        for (int i = 1; i <= 5; i++) begin
            press(BTN_MODE);
            check_eq("o_mode", int'(o_mode), i % 4);
        end
        for (int i = 1; i <= 4; i++) begin
            press(BTN_POS);
            check_eq("o_position", int'(o_position), i % 3);
        end
    endtask

    task automatic test_setup_rollover();
        int target [3];
        int k;
        apply_reset();
        press(BTN_MODE);
        check_eq("o_mode", int'(o_mode), int'(MODE_SETUP));
        // Seconds always wrap past 59 here
        rng = xorshift32(rng);
        k = 60 + int'(rng % 32'd30);
        step_field(0, k);
        rng = xorshift32(rng);
        k = 1 + int'(rng % 32'd90);
        step_field(1, k);
        rng = xorshift32(rng);
        k = 1 + int'(rng % 32'd40);
        step_field(2, k);
        wait_period();
        check_display(exp_t[2], exp_t[1], exp_t[0]);
        target = '{58, 59, 23};
        for (int p = 0; p < 3; p++) begin
            step_field(p, (target[p] - exp_t[p] + field_limit(p) + 1) % (field_limit(p) + 1));
        end
        press_n(BTN_MODE, 3);
        check_eq("o_mode", int'(o_mode), int'(MODE_CLOCK));
        wait_display(23, 59, 59, 2 * CLKS_PER_SEC);
        wait_display(0, 0, 0, CLKS_PER_SEC);
    endtask

    task automatic test_alarm_ring();
        int n;
        apply_reset();
        press_n(BTN_MODE, 2);
        check_eq("o_mode", int'(o_mode), int'(MODE_ALARM));
        press(BTN_CTL);
        check_eq("o_alarm_en", int'(o_alarm_en), 1);
        press_n(BTN_INC, 8);
        check_display(0, 0, 8);
        press_n(BTN_MODE, 2);
        check_eq("o_mode", int'(o_mode), int'(MODE_CLOCK));
        n = 0;
        while (!o_alarm && n < 10 * CLKS_PER_SEC) begin
            @(negedge clk);
            n++;
        end
        check_true(o_alarm, "Alarm never rang at the stored alarm time");
        check_display(0, 0, 8);
        for (int i = 0; i < 4; i++) begin
            wait_period();
            check_eq("o_alarm", int'(o_alarm), 1);
        end
        wait_period();
        check_eq("o_alarm", int'(o_alarm), 0);
        // Same again with the alarm switched off
        press(BTN_CTL);
        check_eq("o_alarm_en", int'(o_alarm_en), 0);
        press_n(BTN_MODE, 2);
        press_n(BTN_INC, 22);
        check_display(0, 0, 30);
        press_n(BTN_MODE, 2);
        wait_display(0, 0, 30, 20 * CLKS_PER_SEC);
        repeat (2 * CLKS_PER_SEC) begin
            @(negedge clk);
            check_eq("o_alarm", int'(o_alarm), 0);
        end
    endtask

    task automatic test_countdown();
        apply_reset();
        press(BTN_CTL);
        check_eq("o_alarm_en", int'(o_alarm_en), 1);
        press_n(BTN_MODE, 3);
        check_eq("o_mode", int'(o_mode), int'(MODE_TIMER));
        press_n(BTN_INC, 3);
        check_display(0, 0, 3);
        press(BTN_CTL);
        check_eq("o_running", int'(o_running), 1);
        wait_display(0, 0, 2, CLKS_PER_SEC);
        wait_display(0, 0, 1, CLKS_PER_SEC);
        wait_display(0, 0, 0, CLKS_PER_SEC);
        check_eq("o_running", int'(o_running), 1);
        @(negedge clk);
        check_eq("o_running", int'(o_running), 0);
        check_eq("o_alarm", int'(o_alarm), 1);
        wait_period();
        check_display(0, 0, 0);
        press(BTN_CTL);
        check_eq("o_running", int'(o_running), 0);
        check_eq("o_alarm_en", int'(o_alarm_en), 1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Simulation timed out before the tests finished");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        rst_n      = 1'b0;
        i_mode_btn = 1'b0;
        i_pos_btn  = 1'b0;
        i_inc_btn  = 1'b0;
        i_ctl_btn  = 1'b0;
        rng        = 32'hd0df;
        test_reset_and_count();
        test_mode_position();
        test_setup_rollover();
        test_alarm_ring();
        test_countdown();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: hw/digital_clock_top.sv
//==============================
// Alarm clock top level and
// display field select
//==============================
`timescale 1ns/1ns

module digital_clock_top import clock_pkg::*; #(
    parameter int CLKS_PER_SEC = 50_000_000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_mode_btn,
    input  logic               i_pos_btn,
    input  logic               i_inc_btn,
    input  logic               i_ctl_btn,
    output logic [FIELD_W-1:0] o_hour,
    output logic [FIELD_W-1:0] o_min,
    output logic [FIELD_W-1:0] o_sec,
    output mode_t              o_mode,
    output pos_t               o_position,
    output logic               o_running,
    output logic               o_alarm_en,
    output logic               o_alarm
);

    logic               tick;
    logic               time_tick;
    logic               time_inc;
    logic               alarm_inc;
    logic               timer_inc;
    logic               timer_tick;
    logic               timer_done;
    logic               timer_zero;
    logic [FIELD_W-1:0] time_hour, time_min, time_sec;
    logic [FIELD_W-1:0] alm_hour, alm_min, alm_sec;
    logic [FIELD_W-1:0] tmr_hour, tmr_min, tmr_sec;

    sec_tick_gen #(
        .CLKS_PER_SEC (CLKS_PER_SEC)
    ) u_tick (
        .clk    (clk),
        .rst_n  (rst_n),
        .o_tick (tick)
    );

    mode_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_mode_btn   (i_mode_btn),
        .i_pos_btn    (i_pos_btn),
        .i_inc_btn    (i_inc_btn),
        .i_ctl_btn    (i_ctl_btn),
        .i_tick       (tick),
        .i_timer_zero (timer_zero),
        .o_mode       (o_mode),
        .o_position   (o_position),
        .o_running    (o_running),
        .o_alarm_en   (o_alarm_en),
        .o_time_tick  (time_tick),
        .o_time_inc   (time_inc),
        .o_alarm_inc  (alarm_inc),
        .o_timer_inc  (timer_inc),
        .o_timer_tick (timer_tick),
        .o_timer_done (timer_done)
    );

    hms_counter u_time (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_tick     (time_tick),
        .i_inc      (time_inc),
        .i_position (o_position),
        .o_hour     (time_hour),
        .o_min      (time_min),
        .o_sec      (time_sec)
    );

    timer_counter u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_tick     (timer_tick),
        .i_inc      (timer_inc),
        .i_position (o_position),
        .o_hour     (tmr_hour),
        .o_min      (tmr_min),
        .o_sec      (tmr_sec),
        .o_zero     (timer_zero)
    );

    alarm_unit u_alarm (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_tick       (tick),
        .i_inc        (alarm_inc),
        .i_position   (o_position),
        .i_alarm_en   (o_alarm_en),
        .i_timer_done (timer_done),
        .i_hour       (time_hour),
        .i_min        (time_min),
        .i_sec        (time_sec),
        .o_hour       (alm_hour),
        .o_min        (alm_min),
        .o_sec        (alm_sec),
        .o_alarm      (o_alarm)
    );

    // Show whatever the current mode edits
    always_comb begin
        case (o_mode)
            MODE_ALARM: {o_hour, o_min, o_sec} = {alm_hour, alm_min, alm_sec};
            MODE_TIMER: {o_hour, o_min, o_sec} = {tmr_hour, tmr_min, tmr_sec};
            default:    {o_hour, o_min, o_sec} = {time_hour, time_min, time_sec};
        endcase
    end

endmodule

// File: hw/alarm_unit.sv
//==============================
// Alarm time, match detect and
// five-second ring
//==============================
`timescale 1ns/1ns

module alarm_unit import clock_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_tick,
    input  logic               i_inc,
    input  pos_t               i_position,
    input  logic               i_alarm_en,
    input  logic               i_timer_done,
    input  logic [FIELD_W-1:0] i_hour,
    input  logic [FIELD_W-1:0] i_min,
    input  logic [FIELD_W-1:0] i_sec,
    output logic [FIELD_W-1:0] o_hour,
    output logic [FIELD_W-1:0] o_min,
    output logic [FIELD_W-1:0] o_sec,
    output logic               o_alarm
);

    logic       match;
    logic       match_d;
    logic       ring_start;
    logic [2:0] ring_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_hour <= '0;
            o_min  <= '0;
            o_sec  <= '0;
        end else if (i_inc) begin
            case (i_position)
                POS_SEC:  o_sec  <= field_step(o_sec, SEC_MAX);
                POS_MIN:  o_min  <= field_step(o_min, MIN_MAX);
                POS_HOUR: o_hour <= field_step(o_hour, HOUR_MAX);
                default:  ;
            endcase
        end
    end

    assign match      = (i_hour == o_hour) && (i_min == o_min) && (i_sec == o_sec);
    assign ring_start = i_alarm_en && ((match && !match_d) || i_timer_done);

    // match_d starts high so that 00:00:00 out of reset is no edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match_d  <= 1'b1;
            o_alarm  <= 1'b0;
            ring_cnt <= '0;
        end else begin
            match_d <= match;
            if (ring_start) begin
                o_alarm  <= 1'b1;
                ring_cnt <= '0;
            end else if (o_alarm && i_tick) begin
                if (ring_cnt == ALARM_RING_SECS - 3'd1) begin
                    o_alarm  <= 1'b0;
                    ring_cnt <= '0;
                end else begin
                    ring_cnt <= ring_cnt + 3'd1;
                end
            end
        end
    end

    a_ring_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(o_alarm) |-> $past(i_alarm_en));

endmodule

// File: hw/timer_counter.sv
//==============================
// Countdown timer with zero flag
//==============================
`timescale 1ns/1ns

module timer_counter import clock_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_tick,
    input  logic               i_inc,
    input  pos_t               i_position,
    output logic [FIELD_W-1:0] o_hour,
    output logic [FIELD_W-1:0] o_min,
    output logic [FIELD_W-1:0] o_sec,
    output logic               o_zero
);

    assign o_zero = (o_hour == '0) && (o_min == '0) && (o_sec == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_hour <= '0;
            o_min  <= '0;
            o_sec  <= '0;
        end else if (i_tick && !o_zero) begin
            // Borrow down through the fields
            if (o_sec != '0) begin
                o_sec <= o_sec - FIELD_W'(1);
            end else begin
                o_sec <= SEC_MAX;
                if (o_min != '0) begin
                    o_min <= o_min - FIELD_W'(1);
                end else begin
                    o_min  <= MIN_MAX;
                    o_hour <= o_hour - FIELD_W'(1);
                end
            end
        end else if (i_inc) begin
            case (i_position)
                POS_SEC:  o_sec  <= field_step(o_sec, SEC_MAX);
                POS_MIN:  o_min  <= field_step(o_min, MIN_MAX);
                POS_HOUR: o_hour <= field_step(o_hour, HOUR_MAX);
                default:  ;
            endcase
        end
    end

    // Run state drops one cycle after reaching zero
    a_no_tick_at_rest: assert property (@(posedge clk) disable iff (!rst_n)
        (o_zero && $past(o_zero)) |-> !i_tick);

endmodule

// File: hw/hms_counter.sv
//==============================
// Time-of-day counter
//==============================
`timescale 1ns/1ns

module hms_counter import clock_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_tick,
    input  logic               i_inc,
    input  pos_t               i_position,
    output logic [FIELD_W-1:0] o_hour,
    output logic [FIELD_W-1:0] o_min,
    output logic [FIELD_W-1:0] o_sec
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_hour <= '0;
            o_min  <= '0;
            o_sec  <= '0;
        end else if (i_tick) begin
            o_sec <= field_step(o_sec, SEC_MAX);
            if (o_sec == SEC_MAX) begin
                o_min <= field_step(o_min, MIN_MAX);
                // 23:59:59 rolls over to midnight
                if (o_min == MIN_MAX) begin
                    o_hour <= field_step(o_hour, HOUR_MAX);
                end
            end
        end else if (i_inc) begin
            // No carry when stepping by hand
            case (i_position)
                POS_SEC:  o_sec  <= field_step(o_sec, SEC_MAX);
                POS_MIN:  o_min  <= field_step(o_min, MIN_MAX);
                POS_HOUR: o_hour <= field_step(o_hour, HOUR_MAX);
                default:  ;
            endcase
        end
    end

    a_fields_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (o_sec <= SEC_MAX) && (o_min <= MIN_MAX) && (o_hour <= HOUR_MAX));

endmodule

// File: hw/mode_ctrl.sv
//==============================
// Mode, position, run and alarm
// enable state, strobe routing
//==============================
`timescale 1ns/1ns

module mode_ctrl import clock_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_mode_btn,
    input  logic  i_pos_btn,
    input  logic  i_inc_btn,
    input  logic  i_ctl_btn,
    input  logic  i_tick,
    input  logic  i_timer_zero,
    output mode_t o_mode,
    output pos_t  o_position,
    output logic  o_running,
    output logic  o_alarm_en,
    output logic  o_time_tick,
    output logic  o_time_inc,
    output logic  o_alarm_inc,
    output logic  o_timer_inc,
    output logic  o_timer_tick,
    output logic  o_timer_done
);

    logic ctl_timer;

    assign ctl_timer    = i_ctl_btn && (o_mode == MODE_TIMER);
    assign o_timer_done = o_running && i_timer_zero;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_mode     <= MODE_CLOCK;
            o_position <= POS_SEC;
            o_running  <= 1'b0;
            o_alarm_en <= 1'b0;
        end else begin
            if (i_mode_btn) begin
                o_mode <= mode_t'(o_mode + 2'd1);
            end
            if (i_pos_btn) begin
                case (o_position)
                    POS_SEC:  o_position <= POS_MIN;
                    POS_MIN:  o_position <= POS_HOUR;
                    default:  o_position <= POS_SEC;
                endcase
            end
            // Expiry wins over a press in the same cycle
            if (o_timer_done) begin
                o_running <= 1'b0;
            end else if (ctl_timer) begin
                o_running <= !o_running && !i_timer_zero;
            end
            if (i_ctl_btn && !ctl_timer) begin
                o_alarm_en <= !o_alarm_en;
            end
        end
    end

    // Each strobe goes only to the counter the mode owns
    assign o_time_tick  = i_tick && (o_mode != MODE_SETUP);
    assign o_time_inc   = i_inc_btn && (o_mode == MODE_SETUP);
    assign o_alarm_inc  = i_inc_btn && (o_mode == MODE_ALARM);
    assign o_timer_inc  = i_inc_btn && (o_mode == MODE_TIMER) && !o_running;
    assign o_timer_tick = i_tick && o_running;

    // Stopped after any cycle at zero, by expiry or by an ignored start
    a_stop_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
        i_timer_zero |=> !o_running);

endmodule

// File: hw/sec_tick_gen.sv
//==============================
// One-second strobe divider
//==============================
`timescale 1ns/1ns

module sec_tick_gen #(
    parameter int CLKS_PER_SEC = 50_000_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic o_tick
);

    localparam int CNT_W = (CLKS_PER_SEC > 1) ? $clog2(CLKS_PER_SEC) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_SEC - 1);

    logic [CNT_W-1:0] cycle_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (cycle_cnt == CNT_LAST) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + CNT_W'(1);
        end
    end

    // Strobe on the wrap cycle
    assign o_tick = (cycle_cnt == CNT_LAST);

endmodule

// File: hw/clock_pkg.sv
//==============================
// Modes, field positions, field
// limits and the alarm ring length
//==============================
package clock_pkg;

    typedef enum logic [1:0] {
        MODE_CLOCK,
        MODE_SETUP,
        MODE_ALARM,
        MODE_TIMER
    } mode_t;

    typedef enum logic [1:0] {
        POS_SEC,
        POS_MIN,
        POS_HOUR
    } pos_t;

    localparam int FIELD_W = 6;

    localparam logic [FIELD_W-1:0] SEC_MAX  = 6'd59;
    localparam logic [FIELD_W-1:0] MIN_MAX  = 6'd59;
    localparam logic [FIELD_W-1:0] HOUR_MAX = 6'd23;

    localparam logic [2:0] ALARM_RING_SECS = 3'd5;

    // Step one field, back to zero past its limit
    function automatic logic [FIELD_W-1:0] field_step(
        input logic [FIELD_W-1:0] value,
        input logic [FIELD_W-1:0] limit
    );
        return (value >= limit) ? '0 : value + FIELD_W'(1);
    endfunction

endpackage
